// ==== build.f ====
+incdir+include
hw/conv_pkg.sv
hw/conv_window_fetch.sv
hw/conv_window_fifo.sv
hw/conv_mac_requant.sv
hw/conv_top.sv
tests/conv_tb.sv

// ==== hw/conv_mac_requant.sv ====
`timescale 1ns/10ps

`include "conv_defines.svh"

module conv_mac_requant import conv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  row_t      num_row,
	input  acc_t      bias,
	input  codebook_t w8,
	input  widx_t     weight_idx,
	input  logic      fifo_empty,
	output logic      win_pop,
	input  window_t   win_q,
	output logic      output_en,
	output addr_t     output_addr,
	output pixel_t    output_wdata,
	output logic      finish
);

	localparam int W = `CONV_PIX_W;
	localparam int TAPS = `CONV_TAPS;
	localparam acc_t PIX_MAX = acc_t'((1 << (W - 1)) - 1);
	localparam acc_t PIX_MIN = acc_t'(-(1 << (W - 1)));

	pixel_t weight [TAPS];
	acc_t prod [TAPS];
	acc_t bias_q;
	row_t num_row_q;
	addr_t total;

	logic pop_d;
	logic prod_v;

	acc_t sum;
	acc_t shifted;
	pixel_t clamped;

	// take a window whenever one is waiting
	assign win_pop = !fifo_empty;

	assign total = addr_t'(num_row_q) * addr_t'(num_row_q);

	// job setup, weights looked up once per start
	always_ff @(posedge clk) begin
		if (start) begin
			bias_q <= bias;
			num_row_q <= num_row;
			for (int t = 0; t < TAPS; t++) begin
				weight[t] <= w8[weight_idx[2*t +: 2]*W +: W];
			end
		end
	end

	always_comb begin
		sum = bias_q;
		for (int t = 0; t < TAPS; t++) begin
			sum = sum + prod[t];
		end
		// floor shift, then saturate to 8 bits
		shifted = sum >>> `CONV_SHIFT;
		if (shifted > PIX_MAX)
			clamped = pixel_t'(PIX_MAX);
		else if (shifted < PIX_MIN)
			clamped = pixel_t'(PIX_MIN);
		else
			clamped = pixel_t'(shifted);
	end

	// stage one products, stage two requantized result
	always_ff @(posedge clk) begin
		if (pop_d) begin
			for (int t = 0; t < TAPS; t++) begin
				prod[t] <= pixel_t'(win_q[t*W +: W]) * weight[t];
			end
		end
		if (prod_v)
			output_wdata <= clamped;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pop_d <= 1'b0;
			prod_v <= 1'b0;
			output_en <= 1'b0;
		end else begin
			pop_d <= win_pop;
			prod_v <= pop_d;
			output_en <= prod_v;
		end
	end

	// address doubles as the write count
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			output_addr <= '0;
			finish <= 1'b0;
		end else if (start) begin
			output_addr <= '0;
			finish <= 1'b0;
		end else if (output_en) begin
			output_addr <= output_addr + addr_t'(1);
			if (output_addr == total - addr_t'(1))
				finish <= 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst) output_en |-> output_addr < total);

endmodule

// ==== hw/conv_pkg.sv ====
`include "conv_defines.svh"

package conv_pkg;

	typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;

	// image side or coordinate
	typedef logic [`CONV_ROW_W-1:0] row_t;

	// pixel index, r * side + c
	typedef logic [`CONV_ADDR_W-1:0] addr_t;

	// tap 0 in the low byte, row-major
	typedef logic [`CONV_TAPS*`CONV_PIX_W-1:0] window_t;

	// four entries, entry 0 in the low byte
	typedef logic [4*`CONV_PIX_W-1:0] codebook_t;

	// 2-bit codebook index per tap
	typedef logic [2*`CONV_TAPS-1:0] widx_t;

	typedef enum logic [1:0] {
		fetch_idle,
		fetch_room,
		fetch_load,
		fetch_done
	} fetch_state_t;

endpackage

// ==== hw/conv_top.sv ====
`timescale 1ns/10ps

module conv_top import conv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  row_t      num_row,
	input  acc_t      bias,
	input  codebook_t w8,
	input  widx_t     weight_idx,

	output logic      input_en,
	output addr_t     input_addr,
	input  pixel_t    input_rdata,

	output logic      output_en,
	output addr_t     output_addr,
	output pixel_t    output_wdata,

	output logic      finish
);

	logic    win_push;
	window_t win_data;
	logic    fifo_full;
	logic    fifo_empty;
	logic    win_pop;
	window_t win_q;

	// producer, walks positions and gathers windows
	conv_window_fetch fetch_i (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.num_row     (num_row),
		.input_en    (input_en),
		.input_addr  (input_addr),
		.input_rdata (input_rdata),
		.fifo_full   (fifo_full),
		.win_push    (win_push),
		.win_data    (win_data)
	);

	conv_window_fifo fifo_i (
		.clk        (clk),
		.rst        (rst),
		.win_push   (win_push),
		.win_data   (win_data),
		.win_pop    (win_pop),
		.win_q      (win_q),
		.fifo_full  (fifo_full),
		.fifo_empty (fifo_empty)
	);

	// consumer, three cycles from pop to write
	conv_mac_requant mac_i (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.num_row      (num_row),
		.bias         (bias),
		.w8           (w8),
		.weight_idx   (weight_idx),
		.fifo_empty   (fifo_empty),
		.win_pop      (win_pop),
		.win_q        (win_q),
		.output_en    (output_en),
		.output_addr  (output_addr),
		.output_wdata (output_wdata),
		.finish       (finish)
	);

endmodule

// ==== hw/conv_window_fetch.sv ====
`timescale 1ns/10ps

`include "conv_defines.svh"

module conv_window_fetch import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    start,
	input  row_t    num_row,
	output logic    input_en,
	output addr_t   input_addr,
	input  pixel_t  input_rdata,
	input  logic    fifo_full,
	output logic    win_push,
	output window_t win_data
);

	localparam int W = `CONV_PIX_W;
	localparam int ROW_BITS = 3 * W;

	fetch_state_t state;
	row_t num_row_q;
	row_t row_cnt;
	row_t col_cnt;
	logic [1:0] tap_r;
	logic [1:0] tap_c;
	logic sweep_done;
	logic pend;
	logic [3:0] pend_tap;
	window_t win;

	row_t img_r;
	row_t img_c;
	logic tap_in;
	logic first_col;
	logic last_tap;
	logic last_col;
	logic last_row;
	logic load_go;

	// image coordinate of the current tap wraps to 31 above or left of the image
	assign img_r = row_cnt + row_t'(tap_r) - row_t'(1);
	assign img_c = col_cnt + row_t'(tap_c) - row_t'(1);

	// side is at most 31 so the wrapped value always fails this
	assign tap_in = (img_r < num_row_q) && (img_c < num_row_q);

	assign first_col = col_cnt == '0;
	assign last_tap = (tap_r == 2'd2) && (tap_c == 2'd2);
	assign last_col = col_cnt == num_row_q - row_t'(1);
	assign last_row = row_cnt == num_row_q - row_t'(1);
	assign load_go = (state == fetch_room) && !fifo_full && !start;

	assign input_en = (state == fetch_load) && !sweep_done && tap_in;
	assign input_addr = addr_t'(img_r) * addr_t'(num_row_q) + addr_t'(img_c);

	// push once the last read has landed in the window
	assign win_push = (state == fetch_load) && sweep_done && !pend;
	assign win_data = win;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= fetch_idle;
			num_row_q <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
			tap_r <= '0;
			tap_c <= '0;
			sweep_done <= 1'b0;
			pend <= 1'b0;
		end else if (start) begin
			state <= fetch_room;
			num_row_q <= num_row;
			row_cnt <= '0;
			col_cnt <= '0;
			sweep_done <= 1'b0;
			pend <= 1'b0;
		end else begin
			pend <= input_en;
			case (state)
				fetch_room: begin
					if (!fifo_full) begin
						state <= fetch_load;
						tap_r <= '0;
						tap_c <= first_col ? 2'd0 : 2'd2;
						sweep_done <= 1'b0;
					end
				end
				fetch_load: begin
					if (!sweep_done) begin
						if (last_tap) begin
							sweep_done <= 1'b1;
						end else if (tap_c == 2'd2) begin
							tap_r <= tap_r + 2'd1;
							tap_c <= first_col ? 2'd0 : 2'd2;
						end else begin
							tap_c <= tap_c + 2'd1;
						end
					end else if (!pend) begin
						// window pushed this cycle so step to the next position
						if (last_col) begin
							col_cnt <= '0;
							if (last_row) begin
								state <= fetch_done;
							end else begin
								row_cnt <= row_cnt + row_t'(1);
								state <= fetch_room;
							end
						end else begin
							col_cnt <= col_cnt + row_t'(1);
							state <= fetch_room;
						end
					end
				end
				default: state <= state;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load_go) begin
			if (first_col) begin
				win <= '0;
			end else begin
				// slide left and start the new right column as padding
				for (int r = 0; r < 3; r++) begin
					win[r*ROW_BITS +: ROW_BITS] <= {{W{1'b0}}, win[r*ROW_BITS + W +: 2*W]};
				end
			end
		end else if (pend) begin
			win[pend_tap*W +: W] <= input_rdata;
		end
		if (input_en) begin
			pend_tap <= {tap_r, 1'b0} + tap_r + tap_c;
		end
	end

	// reads stay inside the image
	assert property (@(posedge clk) disable iff (!rst)
		input_en |-> input_addr < addr_t'(num_row_q) * addr_t'(num_row_q));

endmodule

// ==== hw/conv_window_fifo.sv ====
`timescale 1ns/10ps

`include "conv_defines.svh"

module conv_window_fifo import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    win_push,
	input  window_t win_data,
	input  logic    win_pop,
	output window_t win_q,
	output logic    fifo_full,
	output logic    fifo_empty
);

	localparam int DEPTH = `CONV_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	window_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign fifo_full = count == (PTR_W + 1)'(DEPTH);
	assign fifo_empty = count == '0;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (win_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (win_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({win_push, win_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// registered read, data one cycle after the pop
	always_ff @(posedge clk) begin
		if (win_push)
			mem[wr_ptr] <= win_data;
		if (win_pop)
			win_q <= mem[rd_ptr];
	end

	assert property (@(posedge clk) disable iff (!rst) fifo_full |-> !win_push);
	assert property (@(posedge clk) disable iff (!rst) fifo_empty |-> !win_pop);

endmodule

// ==== include/conv_defines.svh ====
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// pixel and weight width
`define CONV_PIX_W 8

`define CONV_TAPS 9

// products, bias and running sum
`define CONV_ACC_W 16

// requantize shift
`define CONV_SHIFT 5

// image side up to 31
`define CONV_ROW_W 5
`define CONV_ADDR_W 10

// windows buffered between fetch and mac
`define CONV_FIFO_DEPTH 4

`endif

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module conv_tb -o conv_sim
./obj_dir/conv_sim | tee sim.log
if grep -qx "No errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// ==== tests/conv_tb.sv ====
`timescale 1ns/10ps

module conv_tb import conv_pkg::*; ();

	localparam int NUM_TESTS = 7;

	logic      clk;
	logic      rst;
	logic      start;
	row_t      num_row;
	acc_t      bias;
	codebook_t w8;
	widx_t     weight_idx;
	logic      input_en;
	addr_t     input_addr;
	pixel_t    input_rdata;
	logic      output_en;
	addr_t     output_addr;
	pixel_t    output_wdata;
	logic      finish;

	pixel_t in_mem [1024];
	pixel_t out_mem [1024];
	int write_count;
	int errors;
	logic [15:0] lfsr_state;
	string test_name;

	conv_top dut_i (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.num_row      (num_row),
		.bias         (bias),
		.w8           (w8),
		.weight_idx   (weight_idx),
		.input_en     (input_en),
		.input_addr   (input_addr),
		.input_rdata  (input_rdata),
		.output_en    (output_en),
		.output_addr  (output_addr),
		.output_wdata (output_wdata),
		.finish       (finish)
	);

	always #5 clk = ~clk;

	// one cycle read latency with data driven just after the edge
	always @(posedge clk) begin : input_model
		addr_t rd_addr;
		logic rd_en;
		rd_addr = input_addr;
		rd_en = input_en;
		#1;
		if (rd_en)
			input_rdata = in_mem[rd_addr];
	end

	always @(posedge clk) begin
		if (rst && output_en) begin
			check_value({test_name, " write order"}, write_count, int'(output_addr));
			if (finish) begin
				errors++;
				$display("write to address %0d while finish was high", output_addr);
			end
			out_mem[output_addr] = output_wdata;
			write_count++;
		end
	end

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic int test_side(input int k);
		case (k)
			0: return 8;
			1, 2: return 5;
			3, 4: return 6;
			5: return 7;
			default: return 3;
		endcase
	endfunction

	// expected pixel with zero padding, 16-bit wrap, floor shift and clamp
	function automatic pixel_t ref_pixel(input int n, input int r, input int c,
		input acc_t b, input codebook_t cb, input widx_t idx);
		acc_t sum;
		int rr;
		int cc;
		int tap;
		int sel;
		int pix;
		int wt;
		int res;
		sum = b;
		for (int dr = 0; dr < 3; dr++) begin
			for (int dc = 0; dc < 3; dc++) begin
				rr = r + dr - 1;
				cc = c + dc - 1;
				tap = dr * 3 + dc;
				sel = int'(idx[2*tap +: 2]);
				wt = $signed(cb[8*sel +: 8]);
				if (rr >= 0 && rr < n && cc >= 0 && cc < n)
					pix = in_mem[rr*n + cc];
				else
					pix = 0;
				sum = sum + acc_t'(pix * wt);
			end
		end
		res = sum;
		res = res >>> 5;
		if (res > 127)
			res = 127;
		else if (res < -128)
			res = -128;
		return pixel_t'(res);
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		if (expected != actual) begin
			errors++;
			$display("** Error %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic fill_random(input int n);
		for (int a = 0; a < n * n; a++)
			in_mem[a] = pixel_t'(rand_bits(8));
	endtask

	task automatic fill_const(input int n, input pixel_t v);
		for (int a = 0; a < n * n; a++)
			in_mem[a] = v;
	endtask

	task automatic run_conv(input string name, input int n, input acc_t b,
		input codebook_t cb, input widx_t idx);
		for (int a = 0; a < 1024; a++)
			out_mem[a] = pixel_t'(a ^ (a >> 8) ^ 'h5a);
		write_count = 0;
		test_name = name;
		@(posedge clk);
		#1;
		num_row = row_t'(n);
		bias = b;
		w8 = cb;
		weight_idx = idx;
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
		check_value({name, " finish clear"}, 0, int'(finish));
		do begin
			@(posedge clk);
			#1;
		end while (!finish);
		if (write_count != n * n) begin
			errors++;
			$display("%s: %0d writes before finish, expected %0d", name, write_count, n * n);
		end
		for (int r = 0; r < n; r++) begin
			for (int c = 0; c < n; c++) begin
				check_value($sformatf("%s addr %0d", name, r * n + c),
					ref_pixel(n, r, c, b, cb, idx), out_mem[r*n + c]);
			end
		end
	endtask

	task automatic end_run();
		$display("checks failed: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	initial begin
		codebook_t cb;
		widx_t idx;
		acc_t b;
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		num_row = '0;
		bias = '0;
		w8 = '0;
		weight_idx = '0;
		input_rdata = '0;
		errors = 0;
		write_count = 0;
		test_name = "reset";
		lfsr_state = 16'd74;
		for (int a = 0; a < 1024; a++)
			in_mem[a] = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b1;

		fill_random(test_side(0));
		cb = codebook_t'(rand_bits(32));
		idx = widx_t'(rand_bits(18));
		b = acc_t'(rand_bits(12)) - acc_t'(2048);
		run_conv("random", test_side(0), b, cb, idx);

		// corners see 4 taps, edges 6, inside 9
		fill_const(test_side(1), 8'sd1);
		run_conv("pad_unit", test_side(1), '0, 32'h01010101, '0);
		fill_const(test_side(2), 8'sd1);
		run_conv("pad_scaled", test_side(2), acc_t'(288), 32'h20202020, '0);
		check_value("pad_scaled corner", 13, out_mem[0]);
		check_value("pad_scaled edge", 15, out_mem[2]);
		check_value("pad_scaled centre", 18, out_mem[12]);

		fill_const(test_side(3), 8'sd100);
		run_conv("sat_high", test_side(3), '0, 32'h1e1e1e1e, '0);
		check_value("sat_high corner", 127, out_mem[0]);
		fill_const(test_side(4), -8'sd100);
		run_conv("sat_low", test_side(4), '0, 32'h1e1e1e1e, '0);
		check_value("sat_low corner", -128, out_mem[0]);

		// only the centre tap picks entry 3 and that entry is 32
		fill_random(test_side(5));
		run_conv("codebook", test_side(5), '0, 32'h20000000, 18'h00300);
		for (int a = 0; a < test_side(5) * test_side(5); a++)
			check_value($sformatf("codebook identity %0d", a), in_mem[a], out_mem[a]);

		// smallest image straight after a larger one
		fill_random(test_side(6));
		cb = codebook_t'(rand_bits(32));
		idx = widx_t'(rand_bits(18));
		b = acc_t'(rand_bits(12)) - acc_t'(2048);
		run_conv("min_size", test_side(6), b, cb, idx);

		end_run();
	end

	initial begin : watchdog
		int limit;
		limit = 0;
		for (int k = 0; k < NUM_TESTS; k++)
			limit += 12 * test_side(k) * test_side(k) + 100;
		repeat (limit) @(posedge clk);
		errors++;
		$display("timeout after %0d cycles, simulation stopped", limit);
		if (!finish)
			$display("finish had not risen when the timeout fired");
		end_run();
	end

endmodule
